// ==== src/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

	// Kept mnemonics with branches and JMP
	typedef enum logic [5:0] {
		NOP,
		ADC,
		SBC,
		CMP,
		AND,
		ORA,
		EOR,
		LDA,
		LDX,
		LDY,
		STA,
		STX,
		STY,
		INC,
		DEC,
		ASL,
		LSR,
		INX,
		DEX,
		TAX,
		TXA,
		SEC,
		CLC,
		SEI,
		CLI,
		BCC, BCS,	// Carry branches
		BNE, BEQ,	// Zero branches
		BPL, BMI,	// Sign branches
		BVC, BVS,	// Overflow branches
		JMP
	} opcode_e;

	typedef enum logic [2:0] {
		Imp, Imm, Zp, ZpX, Abs, AbX, AbY, Rel
	} mode_e;

	localparam int STATUS_W = 8;

	// Bit positions in P
	localparam logic [2:0] STATUS_C = 3'd0;
	localparam logic [2:0] STATUS_Z = 3'd1;
	localparam logic [2:0] STATUS_I = 3'd2;
	localparam logic [2:0] STATUS_R = 3'd5;	// Reads as one
	localparam logic [2:0] STATUS_V = 3'd6;
	localparam logic [2:0] STATUS_N = 3'd7;

	localparam logic [STATUS_W-1:0] FLAG_C = STATUS_W'(1) << STATUS_C;
	localparam logic [STATUS_W-1:0] FLAG_Z = STATUS_W'(1) << STATUS_Z;
	localparam logic [STATUS_W-1:0] FLAG_I = STATUS_W'(1) << STATUS_I;
	localparam logic [STATUS_W-1:0] FLAG_R = STATUS_W'(1) << STATUS_R;
	localparam logic [STATUS_W-1:0] FLAG_V = STATUS_W'(1) << STATUS_V;
	localparam logic [STATUS_W-1:0] FLAG_N = STATUS_W'(1) << STATUS_N;

	// Flag groups written by the operations
	localparam logic [STATUS_W-1:0] FLAGS_NZ = FLAG_N | FLAG_Z;
	localparam logic [STATUS_W-1:0] FLAGS_NZC = FLAGS_NZ | FLAG_C;
	localparam logic [STATUS_W-1:0] FLAGS_NZCV = FLAGS_NZC | FLAG_V;

endpackage

// ==== src/seq_ctrl_pkg.sv ====
package seq_ctrl_pkg;

	import cpu_isa_pkg::*;

	typedef enum logic [3:0] {
		ALU_TXA,	// Pass operand A
		ALU_TXB,	// Pass operand B
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_ORA,
		ALU_EOR,
		ALU_ROL,
		ALU_ROR
	} alu_func_e;

	// One-hot operand A source
	typedef struct packed {
		logic con;
		logic acc;
		logic x;
		logic y;
		logic dl;
		logic adl;
		logic adh;
		logic pcl;
		logic pch;
	} alu_a_sel_t;

	typedef struct packed {
		logic bus;
		logic con;
	} alu_b_sel_t;

	// Result destinations
	typedef struct packed {
		logic bus;
		logic acc;
		logic x;
		logic y;
		logic adl;
		logic adh;
		logic pcl;
		logic pch;
	} alu_o_sel_t;

	typedef struct packed {
		alu_func_e func;
		logic cinclr;	// Ignore carry in
		alu_a_sel_t a;
		alu_b_sel_t b;
		alu_o_sel_t o;
	} alu_ctrl_t;

	typedef struct packed {
		logic pc_addr_oe;
		logic ad_addr_oe;
		logic pc_inc;
		logic pc_load;
		logic ins_we;
	} addr_ctrl_t;

	typedef struct packed {
		logic [STATUS_W-1:0] mask;
		logic [STATUS_W-1:0] set;
		logic [STATUS_W-1:0] clr;
	} p_update_t;

	typedef enum logic [2:0] {
		Fetch, Decode, Execute, WriteBack,
		ReadH, ReadHP, Branch, BranchOVF
	} seq_state_e;

	localparam alu_ctrl_t ALU_IDLE = '{
		func: ALU_TXB,
		cinclr: 1'b0,
		a: '{con: 1'b1, default: 1'b0},
		b: '{bus: 1'b1, con: 1'b0},
		o: '0
	};

endpackage

// ==== src/seq_fsm.sv ====
`timescale 1ns/1ps

module seq_fsm
	import cpu_isa_pkg::*, seq_ctrl_pkg::*;
(
	input logic sys,
	input logic rst_n_i,
	input logic bus_rdy_i,
	input logic dl_sign_i,
	input logic alu_cout_i,
	input opcode_e opcode_i,
	input mode_e mode_i,
	input logic [STATUS_W-1:0] p_i,
	output addr_ctrl_t addr_o,
	output alu_ctrl_t fsm_alu_o,
	output logic execute_o,
	output logic rmw_wb_o,
	output logic fetch_o,
	output logic we_o
);

seq_state_e state;
seq_state_e state_next;
logic carry_q;	// ADL carry seen in Decode
logic taken;
logic mem_rmw;

always_ff @(posedge sys or negedge rst_n_i) begin
	if (!rst_n_i) begin
		state <= Fetch;
		carry_q <= 1'b0;
	end else if (bus_rdy_i) begin
		state <= state_next;
		if (state == Decode)
			carry_q <= alu_cout_i;
	end
end

always_comb begin
	case (opcode_i)
	BCC: taken = ~p_i[STATUS_C];
	BCS: taken = p_i[STATUS_C];
	BNE: taken = ~p_i[STATUS_Z];
	BEQ: taken = p_i[STATUS_Z];
	BPL: taken = ~p_i[STATUS_N];
	BMI: taken = p_i[STATUS_N];
	BVC: taken = ~p_i[STATUS_V];
	BVS: taken = p_i[STATUS_V];
	default: taken = 1'b0;
	endcase
end

// Memory operand is read, modified and written back
assign mem_rmw = (opcode_i inside {INC, DEC, ASL, LSR}) && (mode_i != Imp);
assign fetch_o = (state == Fetch);

always_comb begin
	addr_o = '0;
	fsm_alu_o = ALU_IDLE;
	execute_o = 1'b0;
	rmw_wb_o = 1'b0;
	we_o = 1'b0;
	state_next = state;
	case (state)
	Fetch: begin
		addr_o.pc_addr_oe = 1'b1;
		addr_o.pc_inc = 1'b1;
		addr_o.ins_we = 1'b1;
		fsm_alu_o.func = ALU_TXA;	// Zero into ADH
		fsm_alu_o.o.adh = 1'b1;
		state_next = Decode;
	end
	Decode: begin
		addr_o.pc_addr_oe = 1'b1;
		addr_o.pc_inc = 1'b1;
		case (mode_i)
		Imp: begin
			addr_o.pc_inc = 1'b0;	// No operand byte
			execute_o = 1'b1;
			state_next = Fetch;
		end
		Imm: begin
			execute_o = 1'b1;
			state_next = Fetch;
		end
		Zp, Abs: begin
			fsm_alu_o.o.adl = 1'b1;	// Operand into ADL
			state_next = (mode_i == Zp) ? Execute : ReadH;
		end
		ZpX, AbX, AbY: begin
			fsm_alu_o.func = ALU_ADD;	// Index plus operand into ADL
			fsm_alu_o.cinclr = 1'b1;
			fsm_alu_o.a.con = 1'b0;
			fsm_alu_o.a.x = (mode_i != AbY);
			fsm_alu_o.a.y = (mode_i == AbY);
			fsm_alu_o.o.adl = 1'b1;
			state_next = (mode_i == ZpX) ? Execute : ReadH;
		end
		Rel: begin
			if (taken) begin
				addr_o.pc_inc = 1'b0;
				fsm_alu_o.func = ALU_ADD;	// PCL plus offset
				fsm_alu_o.cinclr = 1'b1;
				fsm_alu_o.a = '{pcl: 1'b1, default: 1'b0};
				fsm_alu_o.o.pcl = 1'b1;
				state_next = Branch;
			end else begin
				state_next = Fetch;
			end
		end
		default: state_next = Fetch;
		endcase
	end
	Branch: begin
		addr_o.pc_addr_oe = 1'b1;
		fsm_alu_o.func = dl_sign_i ? ALU_SUB : ALU_ADD;	// Fix PCH on page change
		fsm_alu_o.cinclr = 1'b1;
		fsm_alu_o.a = '{pch: 1'b1, default: 1'b0};
		fsm_alu_o.b = '{bus: 1'b0, con: 1'b1};
		if (carry_q ^ dl_sign_i) begin
			fsm_alu_o.o.pch = 1'b1;
			state_next = BranchOVF;
		end else begin
			addr_o.pc_inc = 1'b1;
			state_next = Fetch;
		end
	end
	BranchOVF: begin
		addr_o.pc_addr_oe = 1'b1;
		addr_o.pc_inc = 1'b1;
		state_next = Fetch;
	end
	ReadH: begin
		addr_o.pc_addr_oe = 1'b1;
		fsm_alu_o.o.adh = 1'b1;	// High byte into ADH
		if (opcode_i == JMP) begin
			addr_o.pc_load = 1'b1;
			state_next = Fetch;
		end else begin
			addr_o.pc_inc = 1'b1;
			if ((mode_i inside {AbX, AbY}) && carry_q)
				state_next = ReadHP;
			else
				state_next = Execute;
		end
	end
	ReadHP: begin
		addr_o.ad_addr_oe = 1'b1;
		fsm_alu_o.func = ALU_ADD;	// ADH plus one
		fsm_alu_o.cinclr = 1'b1;
		fsm_alu_o.a = '{adh: 1'b1, default: 1'b0};
		fsm_alu_o.b = '{bus: 1'b0, con: 1'b1};
		fsm_alu_o.o.adh = 1'b1;
		state_next = Execute;
	end
	Execute: begin
		addr_o.ad_addr_oe = 1'b1;
		if (mem_rmw) begin
			state_next = WriteBack;	// Operand lands in DL
		end else begin
			execute_o = 1'b1;
			state_next = Fetch;
		end
	end
	WriteBack: begin
		addr_o.ad_addr_oe = 1'b1;
		execute_o = 1'b1;
		rmw_wb_o = 1'b1;
		we_o = 1'b1;
		state_next = Fetch;
	end
	default: state_next = Fetch;
	endcase
end

endmodule

// ==== src/op_decoder.sv ====
`timescale 1ns/1ps

module op_decoder
	import cpu_isa_pkg::*, seq_ctrl_pkg::*;
(
	input opcode_e opcode_i,
	input mode_e mode_i,
	input logic execute_i,
	input logic rmw_wb_i,
	input logic fsm_we_i,
	input alu_ctrl_t fsm_alu_i,
	output alu_ctrl_t alu_o,
	output logic bus_we_o,
	output p_update_t p_upd_o
);

always_comb begin
	alu_o = fsm_alu_i;
	bus_we_o = fsm_we_i;
	p_upd_o.mask = FLAG_R;	// R is always written
	p_upd_o.set = '0;
	p_upd_o.clr = '0;
	if (execute_i) begin
		alu_o = ALU_IDLE;
		case (opcode_i)
		ADC, SBC: begin
			alu_o.func = (opcode_i == ADC) ? ALU_ADD : ALU_SUB;	// A op M plus C
			alu_o.a = '{acc: 1'b1, default: 1'b0};
			alu_o.o.acc = 1'b1;
			p_upd_o.mask |= FLAGS_NZCV;
		end
		CMP: begin
			alu_o.func = ALU_SUB;	// Result only reaches P
			alu_o.cinclr = 1'b1;
			alu_o.a = '{acc: 1'b1, default: 1'b0};
			p_upd_o.mask |= FLAGS_NZC;
		end
		AND, ORA, EOR: begin
			case (opcode_i)
			AND: alu_o.func = ALU_AND;
			ORA: alu_o.func = ALU_ORA;
			default: alu_o.func = ALU_EOR;
			endcase
			alu_o.a = '{acc: 1'b1, default: 1'b0};
			alu_o.o.acc = 1'b1;
			p_upd_o.mask |= FLAGS_NZ;
		end
		ASL, LSR: begin
			alu_o.func = (opcode_i == ASL) ? ALU_ROL : ALU_ROR;
			alu_o.cinclr = 1'b1;	// Shift in a zero
			if (mode_i == Imp) begin
				alu_o.a = '{acc: 1'b1, default: 1'b0};
				alu_o.o.acc = 1'b1;
			end else begin
				alu_o.a = '{dl: 1'b1, default: 1'b0};
				alu_o.o.bus = rmw_wb_i;
			end
			p_upd_o.mask |= FLAGS_NZC;
		end
		INC, DEC: begin
			alu_o.func = (opcode_i == INC) ? ALU_ADD : ALU_SUB;	// DL plus or minus one
			alu_o.cinclr = 1'b1;
			alu_o.a = '{dl: 1'b1, default: 1'b0};
			alu_o.b = '{bus: 1'b0, con: 1'b1};
			alu_o.o.bus = rmw_wb_i;
			p_upd_o.mask |= FLAGS_NZ;
		end
		INX, DEX: begin
			alu_o.func = (opcode_i == INX) ? ALU_ADD : ALU_SUB;
			alu_o.cinclr = 1'b1;
			alu_o.a = '{x: 1'b1, default: 1'b0};
			alu_o.b = '{bus: 1'b0, con: 1'b1};
			alu_o.o.x = 1'b1;
			p_upd_o.mask |= FLAGS_NZ;
		end
		LDA, LDX, LDY: begin
			alu_o.o.acc = (opcode_i == LDA);	// Bus into register
			alu_o.o.x = (opcode_i == LDX);
			alu_o.o.y = (opcode_i == LDY);
			p_upd_o.mask |= FLAGS_NZ;
		end
		STA, STX, STY: begin
			alu_o.func = ALU_TXA;	// Register onto bus
			alu_o.a.con = 1'b0;
			alu_o.a.acc = (opcode_i == STA);
			alu_o.a.x = (opcode_i == STX);
			alu_o.a.y = (opcode_i == STY);
			alu_o.o.bus = 1'b1;
			bus_we_o = 1'b1;
		end
		TAX: begin
			alu_o.func = ALU_TXA;
			alu_o.a = '{acc: 1'b1, default: 1'b0};
			alu_o.o.x = 1'b1;
			p_upd_o.mask |= FLAGS_NZ;
		end
		TXA: begin
			alu_o.func = ALU_TXA;
			alu_o.a = '{x: 1'b1, default: 1'b0};
			alu_o.o.acc = 1'b1;
			p_upd_o.mask |= FLAGS_NZ;
		end
		SEC: p_upd_o.set = FLAG_C;
		SEI: p_upd_o.set = FLAG_I;
		CLC: p_upd_o.clr = FLAG_C;
		CLI: p_upd_o.clr = FLAG_I;
		default: ;	// NOP leaves the ALU idle
		endcase
	end
end

endmodule

// ==== src/sequencer.sv ====
`timescale 1ns/1ps

module sequencer
	import cpu_isa_pkg::*, seq_ctrl_pkg::*;
(
	input logic sys,
	input logic rst_n_i,
	input opcode_e opcode_i,
	input mode_e mode_i,
	input logic bus_rdy_i,
	input logic dl_sign_i,
	input logic alu_cout_i,
	input logic [STATUS_W-1:0] p_i,
	output logic fetch_o,
	output logic bus_we_o,
	output addr_ctrl_t addr_o,
	output alu_ctrl_t alu_o,
	output p_update_t p_upd_o
);

alu_ctrl_t fsm_alu;	// Addressing phase control
logic execute;
logic rmw_wb;
logic fsm_we;

seq_fsm u_fsm (
	.sys(sys),
	.rst_n_i(rst_n_i),
	.bus_rdy_i(bus_rdy_i),
	.dl_sign_i(dl_sign_i),
	.alu_cout_i(alu_cout_i),
	.opcode_i(opcode_i),
	.mode_i(mode_i),
	.p_i(p_i),
	.addr_o(addr_o),
	.fsm_alu_o(fsm_alu),
	.execute_o(execute),
	.rmw_wb_o(rmw_wb),
	.fetch_o(fetch_o),
	.we_o(fsm_we)
);

op_decoder u_dec (
	.opcode_i(opcode_i),
	.mode_i(mode_i),
	.execute_i(execute),
	.rmw_wb_i(rmw_wb),
	.fsm_we_i(fsm_we),
	.fsm_alu_i(fsm_alu),
	.alu_o(alu_o),
	.bus_we_o(bus_we_o),
	.p_upd_o(p_upd_o)
);

endmodule

// ==== sim/seq_checks.sv ====
`timescale 1ns/1ps

module seq_checks
	import cpu_isa_pkg::*, seq_ctrl_pkg::*;
(
	input logic sys,
	input logic rst_n_i,
	input opcode_e opcode_i,
	input mode_e mode_i,
	input logic bus_rdy_i,
	input logic dl_sign_i,
	input logic alu_cout_i,
	input logic [STATUS_W-1:0] p_i,
	input logic fetch_i,
	input logic bus_we_i,
	input addr_ctrl_t addr_i,
	input alu_ctrl_t alu_i,
	input p_update_t p_upd_i,
	output logic failed_o
);

localparam p_update_t IDLE_UPD = '{mask: FLAG_R, set: '0, clr: '0};
localparam int IN_W = $bits(opcode_e) + $bits(mode_e) + STATUS_W + 2;
localparam int OUT_W = 2 + $bits(addr_ctrl_t) + $bits(alu_ctrl_t) + $bits(p_update_t);

logic [IN_W-1:0] cur_in;
logic [IN_W-1:0] prev_in;
logic [OUT_W-1:0] cur_out;
logic [OUT_W-1:0] prev_out;
logic prev_valid;
logic prev_rdy;
int idx;	// Cycle index inside the instruction from Fetch at 0
int len_q;
opcode_e op_q;
mode_e mode_q;
logic carry_q;
logic taken_q;
logic page_q;

assign cur_in = {opcode_i, mode_i, p_i, alu_cout_i, dl_sign_i};
assign cur_out = {fetch_i, bus_we_i, addr_i, alu_i, p_upd_i};

task automatic report_mismatch(input string name, input logic [63:0] exp_val,
		input logic [63:0] act_val);
	$display("error at %0t: %s expected %0h got %0h", $time, name, exp_val, act_val);
	failed_o = 1'b1;
endtask

task automatic report_problem(input string what);
	$display("at %0t: %s", $time, what);
	failed_o = 1'b1;
endtask

function automatic logic branch_cond(opcode_e op, logic [STATUS_W-1:0] p);
	logic t;
	case (op)
	BCC, BCS: t = p[STATUS_C];
	BNE, BEQ: t = p[STATUS_Z];
	BPL, BMI: t = p[STATUS_N];
	BVC, BVS: t = p[STATUS_V];
	default: t = 1'b0;
	endcase
	// First of each pair branches on a clear flag
	return (op inside {BCC, BNE, BPL, BVC}) ? !t : t;
endfunction

function automatic int exp_len(opcode_e op, mode_e m, logic carry, logic taken, logic page);
	int n;
	case (m)
	Imp, Imm: n = 2;
	Zp, ZpX: n = 3;
	Abs: n = (op == JMP) ? 3 : 4;
	AbX, AbY: n = 4 + int'(carry);	// Page cross adds one
	default: n = taken ? 3 + int'(carry ^ page) : 2;
	endcase
	if ((op inside {INC, DEC, ASL, LSR}) && m != Imp)
		n = n + 1;	// WriteBack
	return n;
endfunction

function automatic p_update_t exp_flags(opcode_e op);
	p_update_t u;
	logic [STATUS_W-1:0] nz;
	u = IDLE_UPD;
	nz = FLAG_N | FLAG_Z;
	case (op)
	ADC, SBC: u.mask = u.mask | nz | FLAG_C | FLAG_V;
	CMP, ASL, LSR: u.mask = u.mask | nz | FLAG_C;
	LDA, LDX, LDY, AND, ORA, EOR: u.mask = u.mask | nz;
	INC, DEC, INX, DEX, TAX, TXA: u.mask = u.mask | nz;
	SEC: u.set = FLAG_C;
	SEI: u.set = FLAG_I;
	CLC: u.clr = FLAG_C;
	CLI: u.clr = FLAG_I;
	default: ;
	endcase
	return u;
endfunction

always @(negedge sys) begin
	int len_now;
	logic last;
	logic exp_we;
	p_update_t exp_upd;
	if (!rst_n_i) begin
		failed_o = 1'b0;
		idx = 0;
		prev_valid = 1'b0;
		assert (fetch_i) else report_mismatch("fetch_o", 1, fetch_i);
		assert (!bus_we_i) else report_mismatch("bus_we_o", 0, bus_we_i);
		assert (!addr_i.ad_addr_oe) else report_mismatch("ad_addr_oe", 0, addr_i.ad_addr_oe);
		assert (!addr_i.pc_load) else report_mismatch("pc_load", 0, addr_i.pc_load);
		assert (p_upd_i == IDLE_UPD) else report_mismatch("p_upd_o", IDLE_UPD, p_upd_i);
	end else begin
		if (prev_valid && !prev_rdy && cur_in == prev_in) begin
			assert (cur_out == prev_out)
			else report_mismatch("outputs under stall", prev_out, cur_out);
		end
		if (fetch_i && idx != 0) begin	// Previous instruction just ended
			assert (idx == exp_len(op_q, mode_q, carry_q, taken_q, page_q))
			else report_mismatch("instruction length",
				exp_len(op_q, mode_q, carry_q, taken_q, page_q), idx);
			if (mode_q == Rel) begin
				assert ((idx == 2) == !taken_q)
				else report_mismatch("branch skipped", !taken_q, idx == 2);
			end
			idx = 0;
		end
		len_now = (idx == 1) ? exp_len(opcode_i, mode_i, alu_cout_i, 1'b0, 1'b0) : len_q;
		last = (idx != 0) && (idx == len_now - 1);
		exp_upd = last ? exp_flags(opcode_i) : IDLE_UPD;
		exp_we = last && ((opcode_i inside {STA, STX, STY}) ||
			((opcode_i inside {INC, DEC, ASL, LSR}) && mode_i != Imp));
		assert (p_upd_i == exp_upd) else report_mismatch("p_upd_o", exp_upd, p_upd_i);
		assert (bus_we_i == exp_we) else report_mismatch("bus_we_o", exp_we, bus_we_i);
		if (bus_rdy_i) begin
			if (idx == 1) begin	// Decode cycle
				op_q = opcode_i;
				mode_q = mode_i;
				carry_q = alu_cout_i;
				taken_q = branch_cond(opcode_i, p_i);
				len_q = len_now;
			end
			if (idx == 2)
				page_q = dl_sign_i;
			idx = idx + 1;
			if (idx > 6)
				report_problem("the sequencer did not return to Fetch within six ready cycles");
		end
		prev_valid = 1'b1;
		prev_rdy = bus_rdy_i;
		prev_in = cur_in;
		prev_out = cur_out;
	end
end

endmodule

// ==== sim/seq_tb.sv ====
`timescale 1ns/1ps

module seq_tb
	import cpu_isa_pkg::*, seq_ctrl_pkg::*;
();

localparam int NUM_INSTR = 200;
localparam int MAX_CYCLES = NUM_INSTR * 6 * 2;	// Longest instruction doubled for stalls

logic sys = 1'b0;
logic rst_n;
opcode_e opcode;
mode_e mode;
logic bus_rdy;
logic dl_sign;
logic alu_cout;
logic [STATUS_W-1:0] p;
logic fetch;
logic bus_we;
addr_ctrl_t addr;
alu_ctrl_t alu;
p_update_t p_upd;
logic check_failed;
int n_instr;
int cycles;

sequencer u_dut (
	.sys(sys),
	.rst_n_i(rst_n),
	.opcode_i(opcode),
	.mode_i(mode),
	.bus_rdy_i(bus_rdy),
	.dl_sign_i(dl_sign),
	.alu_cout_i(alu_cout),
	.p_i(p),
	.fetch_o(fetch),
	.bus_we_o(bus_we),
	.addr_o(addr),
	.alu_o(alu),
	.p_upd_o(p_upd)
);

seq_checks u_checks (
	.sys(sys),
	.rst_n_i(rst_n),
	.opcode_i(opcode),
	.mode_i(mode),
	.bus_rdy_i(bus_rdy),
	.dl_sign_i(dl_sign),
	.alu_cout_i(alu_cout),
	.p_i(p),
	.fetch_i(fetch),
	.bus_we_i(bus_we),
	.addr_i(addr),
	.alu_i(alu),
	.p_upd_i(p_upd),
	.failed_o(check_failed)
);

function automatic logic legal_pair(opcode_e op, mode_e m);
	case (op)
	ADC, SBC, CMP, AND, ORA, EOR, LDA: return m inside {Imm, Zp, ZpX, Abs, AbX, AbY};
	LDX: return m inside {Imm, Zp, Abs, AbY};
	LDY: return m inside {Imm, Zp, ZpX, Abs, AbX};
	STA: return m inside {Zp, ZpX, Abs, AbX, AbY};
	STX: return m inside {Zp, Abs};
	STY: return m inside {Zp, ZpX, Abs};
	INC, DEC: return m inside {Zp, ZpX, Abs, AbX};
	ASL, LSR: return m inside {Imp, Zp, ZpX, Abs, AbX};
	BCC, BCS, BNE, BEQ, BPL, BMI, BVC, BVS: return m == Rel;
	JMP: return m == Abs;
	default: return m == Imp;	// Register and flag ops
	endcase
endfunction

task automatic pick_instruction(output opcode_e op, output mode_e m);
	do begin
		op = opcode_e'($urandom_range(0, int'(JMP)));
		m = mode_e'($urandom_range(0, 7));
	end while (!legal_pair(op, m));
endtask

initial begin
	forever #5 sys = ~sys;
end

always @(posedge check_failed) begin
	$display("TEST RESULT: FAIL");
	$fatal(1, "a check in seq_checks failed");
end

initial begin
	opcode_e op;
	mode_e m;
	void'($urandom(73250));
	rst_n = 1'b0;
	opcode = NOP;
	mode = Imp;
	bus_rdy = 1'b0;
	dl_sign = 1'b0;
	alu_cout = 1'b0;
	p = '0;
	n_instr = 0;
	cycles = 0;
	repeat (8) @(posedge sys);
	rst_n <= 1'b1;
	// One more start closes the last instruction
	while (n_instr <= NUM_INSTR && cycles < MAX_CYCLES) begin
		@(posedge sys);
		if (bus_rdy) begin	// Inputs hold through stalls
			alu_cout <= 1'($urandom);
			dl_sign <= 1'($urandom);
			if (fetch) begin	// New instruction from Decode on
				pick_instruction(op, m);
				opcode <= op;
				mode <= m;
				p <= STATUS_W'($urandom);
				n_instr++;
			end
		end
		bus_rdy <= ($urandom_range(0, 3) != 0);	// Stall about one cycle in four
		cycles++;
	end
	if (n_instr <= NUM_INSTR) begin
		$display("timeout after %0d cycles with %0d instructions started", cycles, n_instr);
		$display("TEST RESULT: FAIL");
		$fatal(1, "timeout");
	end else if (check_failed) begin
		$display("TEST RESULT: FAIL");
		$fatal(1, "checks failed");
	end else begin
		$display("TEST RESULT: PASS");
		$finish;
	end
end

endmodule

// ==== files.f ====
src/cpu_isa_pkg.sv
src/seq_ctrl_pkg.sv
src/seq_fsm.sv
src/op_decoder.sv
src/sequencer.sv
sim/seq_checks.sv
sim/seq_tb.sv
